/* verilog.f */
+incdir+.
spix_pkg.sv
spix_arbiter.sv
spix_sequencer.sv
spix_shifter.sv
spix_top.sv
tb_flash_model.sv
tb_spix_top.sv

/* tb_spix_top.sv */
`timescale 1ns/1ps
`include "spix_config.svh"

module tb_spix_top
	import spix_pkg::*;
();

	logic clk;
	logic reset;
	logic wb_cyc, wb_stb, wb_we;
	word_addr_t wb_addr;
	data_t wb_data;
	sel_t wb_sel;
	logic wb_stall, wb_ack;
	data_t wb_rdata;
	logic cfg_cyc, cfg_stb, cfg_we;
	data_t cfg_data;
	sel_t cfg_sel;
	logic cfg_stall, cfg_ack;
	data_t cfg_rdata;
	logic spi_cs_n, spi_sck, spi_mosi, spi_miso;
	logic [7:0] flash_cmd;
	logic [23:0] flash_addr;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cs_falls = 0;
	int cs_rises = 0;
	int sck_clocks = 0;
	// Config port let through while memory owned the bus
	int cfg_leaks = 0;
	logic [31:0] seed = 32'hcbd6;

	spix_top UUT (
		.i_clk(clk), .i_reset(reset),
		.i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
		.i_wb_addr(wb_addr), .i_wb_data(wb_data), .i_wb_sel(wb_sel),
		.o_wb_stall(wb_stall), .o_wb_ack(wb_ack), .o_wb_data(wb_rdata),
		.i_cfg_cyc(cfg_cyc), .i_cfg_stb(cfg_stb), .i_cfg_we(cfg_we),
		.i_cfg_data(cfg_data), .i_cfg_sel(cfg_sel),
		.o_cfg_stall(cfg_stall), .o_cfg_ack(cfg_ack), .o_cfg_data(cfg_rdata),
		.o_spi_cs_n(spi_cs_n), .o_spi_sck(spi_sck),
		.o_spi_mosi(spi_mosi), .i_spi_miso(spi_miso)
	);

	tb_flash_model u_flash (
		.i_clk(clk), .i_spi_cs_n(spi_cs_n), .i_spi_sck(spi_sck),
		.i_spi_mosi(spi_mosi), .o_spi_miso(spi_miso),
		.o_cmd(flash_cmd), .o_addr(flash_addr)
	);

	always #2 clk = !clk;

	//////////////////////////////////////////////////
	// Bus monitors
	//////////////////////////////////////////////////

	always @(negedge spi_cs_n) cs_falls++;
	always @(posedge spi_cs_n) cs_rises++;

	always @(posedge clk)
	begin
		if (spi_sck === 1'b1)
			sck_clocks++;
	end

	always @(negedge clk)
	begin
		if (wb_cyc && cfg_cyc && (!cfg_stall || cfg_ack))
			cfg_leaks++;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// Upper LCG bits make the word address
	function automatic word_addr_t pick_word_addr();
		logic [31:0] r;
		r = lcg_next();
		return r[31:32-`SPIX_AW];
	endfunction

	// Random byte that never equals the read command
	// A read command would switch the flash model to read mode
	function automatic spi_byte_t pick_user_byte();
		spi_byte_t b;
		logic [31:0] r;
		r = lcg_next();
		b = r[23:16];
		if (b == `SPIX_READ_CMD)
			b = 8'h5c;
		return b;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic logic stall_of(input bit cfg);
		return cfg ? cfg_stall : wb_stall;
	endfunction

	function automatic logic ack_of(input bit cfg);
		return cfg ? cfg_ack : wb_ack;
	endfunction

	task automatic drive_port(input bit cfg, input bit we, input word_addr_t addr,
		input data_t data);
		if (cfg)
		begin
			cfg_cyc  = 1'b1;
			cfg_stb  = 1'b1;
			cfg_we   = we;
			cfg_data = data;
		end
		else
		begin
			wb_cyc  = 1'b1;
			wb_stb  = 1'b1;
			wb_we   = we;
			wb_addr = addr;
			wb_data = data;
		end
	endtask

	// Waits for acceptance, then ack, then frees the port for an idle cycle
	// Latency counts falling edges after the accepting edge
	// An ack that rises on edge N of the transfer shows up at latency N + 1
	task automatic complete_request(input bit cfg, output data_t rdata, output int latency);
		int waited;
		bit accepted;
		bit acked;
		waited   = 0;
		accepted = 0;
		acked    = 0;
		latency  = 0;
		while (!accepted && waited < 100)
		begin
			@(negedge clk);
			if (!stall_of(cfg))
				accepted = 1;
			else
				waited++;
		end
		@(posedge clk);
		#1;
		if (cfg)
			cfg_stb = 1'b0;
		else
			wb_stb = 1'b0;
		assert (accepted)
		else
		begin
			$display("Request was never accepted, stall stayed high for 100 cycles");
			errors++;
		end
		if (accepted)
		begin
			while (!acked && latency < 100)
			begin
				@(negedge clk);
				latency++;
				if (ack_of(cfg))
					acked = 1;
			end
			assert (acked)
			else
			begin
				$display("No acknowledge arrived within 100 cycles");
				errors++;
			end
		end
		rdata = cfg ? cfg_rdata : wb_rdata;
		@(posedge clk);
		#1;
		if (cfg)
			cfg_cyc = 1'b0;
		else
			wb_cyc = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic run_request(input bit cfg, input bit we, input word_addr_t addr,
		input data_t data, output data_t rdata, output int latency);
		drive_port(cfg, we, addr, data);
		complete_request(cfg, rdata, latency);
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("%s: pass", name);
		else
		begin
			tests_failed++;
			$display("%s: fail, %0d errors", name, errors - errors_before);
		end
	endtask

	// Full flash read with address and data checked against the model
	task automatic check_mem_read(input word_addr_t addr);
		data_t rdata;
		int latency;
		int clocks0;
		clocks0 = sck_clocks;
		run_request(0, 0, addr, '0, rdata, latency);
		check_value("wb_ack latency", latency, `SPIX_READ_LEN + 1);
		// Command, address and data bits each take one SPI clock
		check_value("o_spi_sck cycles", sck_clocks - clocks0, 8 + 24 + 32);
		check_value("o_wb_data", rdata, {8'hA5, addr, 2'b00});
		check_value("flash command", flash_cmd, `SPIX_READ_CMD);
		check_value("flash address", flash_addr, {addr, 2'b00});
		check_value("o_spi_cs_n", spi_cs_n, 1'b1);
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset();
		int e0;
		e0 = errors;
		check_value("o_spi_cs_n", spi_cs_n, 1'b1);
		check_value("o_spi_sck", spi_sck, 1'b0);
		check_value("o_wb_stall", wb_stall, 1'b0);
		check_value("o_wb_ack", wb_ack, 1'b0);
		check_value("o_cfg_stall", cfg_stall, 1'b0);
		check_value("o_cfg_ack", cfg_ack, 1'b0);
		report_test("reset", e0);
	endtask

	task automatic test_mem_read();
		int e0;
		e0 = errors;
		check_mem_read(pick_word_addr());
		report_test("memory read", e0);
	endtask

	task automatic test_mem_write();
		int e0;
		int falls0;
		data_t rdata;
		int latency;
		e0     = errors;
		falls0 = cs_falls;
		run_request(0, 1, pick_word_addr(), lcg_next(), rdata, latency);
		check_value("wb_ack latency", latency, 2);
		check_value("chip select falls", cs_falls, falls0);
		report_test("memory write", e0);
	endtask

	task automatic test_user_mode();
		int e0;
		int rises0;
		spi_byte_t b0;
		spi_byte_t b1;
		data_t rdata;
		int latency;
		e0 = errors;
		b0 = pick_user_byte();
		b1 = pick_user_byte();
		run_request(1, 1, '0, {24'h0, b0}, rdata, latency);
		check_value("cfg_ack latency", latency, `SPIX_BYTE_LEN + 1);
		check_value("o_spi_cs_n", spi_cs_n, 1'b0);
		rises0 = cs_rises;
		run_request(1, 1, '0, {24'h0, b1}, rdata, latency);
		check_value("cfg_ack latency", latency, `SPIX_BYTE_LEN + 1);
		check_value("chip select rises", cs_rises, rises0);
		// Second byte was answered with the inverse of the first
		run_request(1, 0, '0, '0, rdata, latency);
		check_value("cfg_ack latency", latency, 2);
		check_value("o_cfg_data", rdata, {23'h0, 1'b0, ~b0});
		report_test("user mode", e0);
	endtask

	task automatic test_user_exit();
		int e0;
		int clocks0;
		data_t rdata;
		int latency;
		e0      = errors;
		clocks0 = sck_clocks;
		run_request(0, 0, pick_word_addr(), '0, rdata, latency);
		check_value("wb_ack latency", latency, 2);
		check_value("SPI clocks", sck_clocks, clocks0);
		// Bit 8 high releases the flash
		run_request(1, 1, '0, 32'h100, rdata, latency);
		check_value("cfg_ack latency", latency, 2);
		check_value("o_spi_cs_n", spi_cs_n, 1'b1);
		check_mem_read(pick_word_addr());
		report_test("user mode exit", e0);
	endtask

	task automatic test_priority();
		int e0;
		data_t rdata;
		int latency;
		e0        = errors;
		cfg_leaks = 0;
		drive_port(1, 0, '0, '0);
		check_mem_read(pick_word_addr());
		complete_request(1, rdata, latency);
		check_value("cfg_ack latency", latency, 2);
		check_value("config grants during memory", cfg_leaks, 0);
		report_test("priority", e0);
	endtask

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial
	begin
		#20000;
		$display("Simulation ran past its time limit");
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		clk      = 1'b0;
		reset    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_addr  = '0;
		wb_data  = '0;
		wb_sel   = '1;
		cfg_cyc  = 1'b0;
		cfg_stb  = 1'b0;
		cfg_we   = 1'b0;
		cfg_data = '0;
		cfg_sel  = '1;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset();
		test_mem_read();
		test_mem_write();
		test_user_mode();
		test_user_exit();
		test_priority();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* tb_flash_model.sv */
`timescale 1ns/1ps
`include "spix_config.svh"

module tb_flash_model (
	input  logic        i_clk,
	input  logic        i_spi_cs_n,
	input  logic        i_spi_sck,
	input  logic        i_spi_mosi,
	output logic        o_spi_miso,
	output logic [7:0]  o_cmd,
	output logic [23:0] o_addr
);

	// Gated clock seen last cycle, MOSI is stable on the edge after it
	logic sck_d = 1'b0;
	// Bits received in this chip-select session
	int bit_idx = 0;
	logic [7:0] rx;
	// Byte sent back in user mode, inverse of the previous byte
	logic [7:0] resp = 8'h00;
	logic is_read = 1'b0;
	logic [31:0] word;
	logic [7:0] rx_next;
	logic [23:0] addr_next;

	//////////////////////////////////////////////////
	// MOSI side
	//////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		sck_d <= i_spi_sck && !i_spi_cs_n;
		if (i_spi_cs_n)
		begin
			// New session starts clean
			bit_idx <= 0;
			resp    <= 8'h00;
			is_read <= 1'b0;
		end
		else if (sck_d)
		begin
			rx_next = {rx[6:0], i_spi_mosi};
			rx      <= rx_next;
			bit_idx <= bit_idx + 1;
			if (bit_idx % 8 == 7)
				resp <= ~rx_next;
			// First byte of a session is the command
			if (bit_idx == 7)
			begin
				o_cmd   <= rx_next;
				is_read <= (rx_next == `SPIX_READ_CMD);
			end
			if (is_read && bit_idx >= 8 && bit_idx < 32)
			begin
				addr_next = {o_addr[22:0], i_spi_mosi};
				o_addr    <= addr_next;
				// Answer word is ready as the last address bit arrives
				if (bit_idx == 31)
					word <= {8'hA5, addr_next};
			end
		end
	end

	//////////////////////////////////////////////////
	// MISO side
	//////////////////////////////////////////////////

	// Bit for the next capture edge, MSB first
	always_comb
	begin
		if (is_read)
			o_spi_miso = (bit_idx >= 32 && bit_idx < 64) ? word[63 - bit_idx] : 1'b0;
		else
			o_spi_miso = resp[7 - (bit_idx % 8)];
	end

endmodule

/* spix_top.sv */
`timescale 1ns/1ps

module spix_top
	import spix_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	// Memory port
	input  logic       i_wb_cyc,
	input  logic       i_wb_stb,
	input  logic       i_wb_we,
	input  word_addr_t i_wb_addr,
	input  data_t      i_wb_data,
	input  sel_t       i_wb_sel,
	output logic       o_wb_stall,
	output logic       o_wb_ack,
	output data_t      o_wb_data,
	// Configuration port
	input  logic       i_cfg_cyc,
	input  logic       i_cfg_stb,
	input  logic       i_cfg_we,
	input  data_t      i_cfg_data,
	input  sel_t       i_cfg_sel,
	output logic       o_cfg_stall,
	output logic       o_cfg_ack,
	output data_t      o_cfg_data,
	// SPI flash
	output logic       o_spi_cs_n,
	output logic       o_spi_sck,
	output logic       o_spi_mosi,
	input  logic       i_spi_miso
);

	// Arbitrated bus
	logic       bus_cyc;
	logic       bus_stb;
	logic       bus_we;
	logic       bus_cfg;
	word_addr_t bus_addr;
	data_t      bus_data;
	logic       bus_stall;
	logic       bus_ack;

	// Sequencer to shifter
	logic load_read;
	logic load_byte;
	logic shift_en;
	logic capture_en;
	logic user_mode;

	data_t rd_data;

	//////////////////////////////////////////////////
	// Port arbitration, memory first
	//////////////////////////////////////////////////

	spix_arbiter u_arbiter (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_addr   (i_wb_addr),
		.i_wb_data   (i_wb_data),
		.i_wb_sel    (i_wb_sel),
		.o_wb_stall  (o_wb_stall),
		.o_wb_ack    (o_wb_ack),
		.i_cfg_cyc   (i_cfg_cyc),
		.i_cfg_stb   (i_cfg_stb),
		.i_cfg_we    (i_cfg_we),
		.i_cfg_data  (i_cfg_data),
		.i_cfg_sel   (i_cfg_sel),
		.o_cfg_stall (o_cfg_stall),
		.o_cfg_ack   (o_cfg_ack),
		.o_bus_cyc   (bus_cyc),
		.o_bus_stb   (bus_stb),
		.o_bus_we    (bus_we),
		.o_bus_cfg   (bus_cfg),
		.o_bus_addr  (bus_addr),
		.o_bus_data  (bus_data),
		.i_bus_stall (bus_stall),
		.i_bus_ack   (bus_ack)
	);

	// Bit 8 of a config write is the chip-select release
	spix_sequencer u_sequencer (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_bus_cyc    (bus_cyc),
		.i_bus_stb    (bus_stb),
		.i_bus_we     (bus_we),
		.i_bus_cfg    (bus_cfg),
		.i_cfg_hold_n (bus_data[8]),
		.o_bus_stall  (bus_stall),
		.o_bus_ack    (bus_ack),
		.o_load_read  (load_read),
		.o_load_byte  (load_byte),
		.o_shift_en   (shift_en),
		.o_capture_en (capture_en),
		.o_user_mode  (user_mode),
		.o_spi_cs_n   (o_spi_cs_n),
		.o_spi_sck    (o_spi_sck)
	);

	spix_shifter u_shifter (
		.i_clk        (i_clk),
		.i_load_read  (load_read),
		.i_load_byte  (load_byte),
		.i_shift_en   (shift_en),
		.i_capture_en (capture_en),
		.i_user_mode  (user_mode),
		.i_cs_n       (o_spi_cs_n),
		.i_bus_addr   (bus_addr),
		.i_cfg_byte   (bus_data[7:0]),
		.i_spi_miso   (i_spi_miso),
		.o_spi_mosi   (o_spi_mosi),
		.o_rd_data    (rd_data)
	);

	// One read data register serves both ports
	assign o_wb_data  = rd_data;
	assign o_cfg_data = rd_data;

endmodule

/* spix_shifter.sv */
`timescale 1ns/1ps
`include "spix_config.svh"

module spix_shifter
	import spix_pkg::*;
(
	input  logic       i_clk,
	// Control from the sequencer
	input  logic       i_load_read,
	input  logic       i_load_byte,
	input  logic       i_shift_en,
	input  logic       i_capture_en,
	input  logic       i_user_mode,
	input  logic       i_cs_n,
	// Request payload
	input  word_addr_t i_bus_addr,
	input  spi_byte_t  i_cfg_byte,
	// SPI data lines
	input  logic       i_spi_miso,
	output logic       o_spi_mosi,
	// Read data to both ports
	output data_t      o_rd_data
);

	// Lead bit, then command and byte address, or the user byte
	logic [32:0] mosi_sr;
	// Everything seen on MISO, newest bit at the bottom
	data_t miso_sr;

	//////////////////////////////////////////////////
	// MOSI
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_load_read)
			// Byte address is word address with two zero bits
			mosi_sr <= {1'b0, `SPIX_READ_CMD, i_bus_addr, 2'b00};
		else if (i_load_byte)
			mosi_sr <= {1'b0, i_cfg_byte, 24'h0};
		else if (i_shift_en)
			// Zeros fill in behind, MOSI idles low during data
			mosi_sr <= {mosi_sr[31:0], 1'b0};
	end

	// Top bit goes out first
	assign o_spi_mosi = mosi_sr[32];

	//////////////////////////////////////////////////
	// MISO
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_capture_en)
			miso_sr <= {miso_sr[`SPIX_DW-2:0], i_spi_miso};
	end

	// User mode answers with chip select and the last byte only
	always_comb
	begin
		if (i_user_mode)
			o_rd_data = {{(`SPIX_DW-9){1'b0}}, i_cs_n, miso_sr[7:0]};
		else
			o_rd_data = miso_sr;
	end

endmodule

/* spix_sequencer.sv */
`timescale 1ns/1ps
`include "spix_config.svh"

module spix_sequencer
	import spix_pkg::*;
(
	input  logic i_clk,
	input  logic i_reset,
	// Arbitrated bus
	input  logic i_bus_cyc,
	input  logic i_bus_stb,
	input  logic i_bus_we,
	input  logic i_bus_cfg,
	input  logic i_cfg_hold_n,
	output logic o_bus_stall,
	output logic o_bus_ack,
	// Shifter control
	output logic o_load_read,
	output logic o_load_byte,
	output logic o_shift_en,
	output logic o_capture_en,
	output logic o_user_mode,
	// SPI pins
	output logic o_spi_cs_n,
	output logic o_spi_sck
);

	seq_state_t state;
	// Count of gated clocks still to go
	// The transfer ends on the edge where it reads 1
	bit_count_t bit_count;

	logic accept;
	logic read_req;
	logic byte_req;
	logic quick_req;
	logic cfg_write;
	logic last_bit;

	//////////////////////////////////////////////////
	// Request decode
	//////////////////////////////////////////////////

	assign accept = i_bus_cyc && i_bus_stb && !o_bus_stall;

	// Any config write sets or clears user mode
	assign cfg_write = accept && i_bus_we && i_bus_cfg;

	// Flash read only when nobody holds the chip in user mode
	assign read_req = accept && !i_bus_we && !i_bus_cfg && !o_user_mode;
	// Config write with bit 8 low sends one byte
	assign byte_req = cfg_write && !i_cfg_hold_n;
	// Everything else answers on the next cycle with no SPI traffic
	assign quick_req = accept && !read_req && !byte_req;

	assign last_bit = (bit_count == 7'd1);

	//////////////////////////////////////////////////
	// State and bit counter
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_bus_cyc)
		begin
			// Reset or bus abort
			state     <= IDLE;
			bit_count <= '0;
		end
		else if (read_req)
		begin
			state     <= READ;
			bit_count <= `SPIX_READ_LEN;
		end
		else if (byte_req)
		begin
			state     <= USER_BYTE;
			bit_count <= `SPIX_BYTE_LEN;
		end
		else if (quick_req)
		begin
			state     <= QUICK_ACK;
			bit_count <= '0;
		end
		else
		begin
			case (state)
				READ, USER_BYTE:
				begin
					if (bit_count > 7'd1)
						bit_count <= bit_count - 7'd1;
					else
					begin
						bit_count <= '0;
						state     <= IDLE;
					end
				end
				// Quick ack lasts a single cycle
				default:
					state <= IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Handshake
	//////////////////////////////////////////////////

	// Busy from acceptance until the ack edge
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_bus_cyc)
			o_bus_stall <= 1'b0;
		else if (read_req || byte_req)
			o_bus_stall <= 1'b1;
		else
			o_bus_stall <= (bit_count > 7'd1);
	end

	// Ack on the final count or on the edge after a quick request
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_bus_ack <= 1'b0;
		else
			o_bus_ack <= i_bus_cyc && (last_bit || (state == QUICK_ACK));
	end

	//////////////////////////////////////////////////
	// SPI clock, chip select, user mode
	//////////////////////////////////////////////////

	// Clock enable runs from acceptance until two counts remain
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_spi_sck <= 1'b0;
		else if (read_req || byte_req)
			o_spi_sck <= 1'b1;
		else
			o_spi_sck <= i_bus_cyc && (bit_count > 7'd2);
	end

	// MISO is valid one cycle after the clock enable
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_bus_cyc)
			o_capture_en <= 1'b0;
		else
			o_capture_en <= o_spi_sck;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_user_mode <= 1'b0;
		else if (cfg_write)
			o_user_mode <= !i_cfg_hold_n;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_spi_cs_n <= 1'b1;
		else if (!i_bus_cyc && !o_user_mode)
			// Aborted transfer outside user mode
			o_spi_cs_n <= 1'b1;
		else if (read_req)
			o_spi_cs_n <= 1'b0;
		else if (cfg_write)
			// Bit 8 low selects the flash and bit 8 high releases it
			o_spi_cs_n <= i_cfg_hold_n;
		else if (last_bit && (state == READ))
			o_spi_cs_n <= 1'b1;
	end

	// Shifter loads on the accepting edge and moves while stalled
	assign o_load_read = read_req;
	assign o_load_byte = byte_req;
	assign o_shift_en  = o_bus_stall;

endmodule

/* spix_arbiter.sv */
`timescale 1ns/1ps

module spix_arbiter
	import spix_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	// Memory port
	input  logic       i_wb_cyc,
	input  logic       i_wb_stb,
	input  logic       i_wb_we,
	input  word_addr_t i_wb_addr,
	input  data_t      i_wb_data,
	input  sel_t       i_wb_sel,
	output logic       o_wb_stall,
	output logic       o_wb_ack,
	// Configuration port
	input  logic       i_cfg_cyc,
	input  logic       i_cfg_stb,
	input  logic       i_cfg_we,
	input  data_t      i_cfg_data,
	input  sel_t       i_cfg_sel,
	output logic       o_cfg_stall,
	output logic       o_cfg_ack,
	// Internal bus towards the sequencer and shifter
	output logic       o_bus_cyc,
	output logic       o_bus_stb,
	output logic       o_bus_we,
	output logic       o_bus_cfg,
	output word_addr_t o_bus_addr,
	output data_t      o_bus_data,
	input  logic       i_bus_stall,
	input  logic       i_bus_ack
);

	// Bus currently owned by one port
	logic busy;
	// Owner recorded when the bus was taken
	logic owner_cfg;
	// Effective grant this cycle
	logic grant_cfg;

	//////////////////////////////////////////////////
	// Grant
	//////////////////////////////////////////////////

	// Idle bus goes to memory first, config only when memory is quiet
	assign grant_cfg = busy ? owner_cfg : !i_wb_cyc;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			busy      <= 1'b0;
			owner_cfg <= 1'b0;
		end
		else if (!busy)
		begin
			busy      <= i_wb_cyc || i_cfg_cyc;
			owner_cfg <= !i_wb_cyc;
		end
		else if (!o_bus_cyc)
			// Owner dropped cyc, so release for one idle cycle at least
			busy <= 1'b0;
	end

	//////////////////////////////////////////////////
	// Request mux
	//////////////////////////////////////////////////

	assign o_bus_cyc  = grant_cfg ? i_cfg_cyc : i_wb_cyc;
	assign o_bus_stb  = grant_cfg ? i_cfg_stb : i_wb_stb;
	assign o_bus_we   = grant_cfg ? i_cfg_we  : i_wb_we;
	assign o_bus_cfg  = grant_cfg;
	// Config port has no address lines
	assign o_bus_addr = grant_cfg ? '0 : i_wb_addr;
	assign o_bus_data = grant_cfg ? i_cfg_data : i_wb_data;

	// Byte selects i_wb_sel and i_cfg_sel are ignored, every access is a full word

	//////////////////////////////////////////////////
	// Response routing
	//////////////////////////////////////////////////

	// Losing port stalls whenever the bus is in use by the other side
	assign o_wb_stall  = grant_cfg ? (busy || o_bus_cyc) : i_bus_stall;
	assign o_cfg_stall = grant_cfg ? i_bus_stall : (busy || o_bus_cyc);

	assign o_wb_ack  = !grant_cfg && i_bus_ack;
	assign o_cfg_ack = grant_cfg && i_bus_ack;

endmodule

/* spix_pkg.sv */
`include "spix_config.svh"

package spix_pkg;

	//////////////////////////////////////////////////
	// Bus side
	//////////////////////////////////////////////////

	// Word address on the memory port
	typedef logic [`SPIX_AW-1:0] word_addr_t;

	// Bus data word, both ports
	typedef logic [`SPIX_DW-1:0] data_t;

	// Byte selects, carried but not acted on
	typedef logic [`SPIX_DW/8-1:0] sel_t;

	//////////////////////////////////////////////////
	// SPI side
	//////////////////////////////////////////////////

	// One byte on MOSI or MISO
	typedef logic [7:0] spi_byte_t;

	// Remaining gated clocks, wide enough for a full read
	typedef logic [6:0] bit_count_t;

	// Transfer sequencer states
	typedef enum logic [1:0] {
		IDLE,
		READ,
		USER_BYTE,
		QUICK_ACK
	} seq_state_t;

endpackage

/* spix_config.svh */
`ifndef SPIX_CONFIG_SVH
`define SPIX_CONFIG_SVH

//////////////////////////////////////////////////
// Bus geometry
//////////////////////////////////////////////////

// Word address, 24-bit flash byte address without its two low bits
`define SPIX_AW 22

// Bus data word
`define SPIX_DW 32

//////////////////////////////////////////////////
// SPI flash transfer
//////////////////////////////////////////////////

// Plain slow read, no dummy cycles
`define SPIX_READ_CMD 8'h03

// Gated clocks in a read: lead + 8 command + 24 address + 32 data
`define SPIX_READ_LEN 7'd65

// Gated clocks in a user byte: lead + 8 data
`define SPIX_BYTE_LEN 7'd9

`endif
